//--- dpe_pkg.sv
/*
 * shared widths, lane count and pipeline depths of the dot product engine,
 * configuration register addresses and the vector typedefs
 */
package dpe_pkg;

	// one beat carries this many int8 lanes on each operand
	localparam int LANES = 16;
	localparam int ELEM_W = 8;
	localparam int PROD_W = 2 * ELEM_W;
	localparam int SUM_W = 32;
	localparam int RES_W = 16;
	localparam int DATA_W = LANES * ELEM_W;

	// one registered adder level per halving of the lane count
	localparam int TREE_STAGES = $clog2(LANES);
	localparam int MULT_LAT = 2;
	localparam int ACC_LAT = 2;
	// cycles from the edge sampling the last beat of a vector to o_valid
	localparam int DPE_LAT = MULT_LAT + TREE_STAGES + ACC_LAT;

	typedef logic signed [ELEM_W-1:0] elem_t;
	typedef logic signed [PROD_W-1:0] prod_t;
	typedef logic signed [SUM_W-1:0] sum_t;
	typedef logic signed [RES_W-1:0] res_t;
	// lane j lives in bits j*ELEM_W upward
	typedef logic [DATA_W-1:0] data_t;
	typedef logic [7:0] chunk_cnt_t;
	typedef logic [4:0] shift_t;
	typedef logic [0:0] cfg_addr_t;
	typedef logic [7:0] cfg_data_t;

	// clamp limits of the signed output, held at accumulator width
	localparam sum_t RES_MAX = sum_t'((2 ** (RES_W - 1)) - 1);
	localparam sum_t RES_MIN = -sum_t'(2 ** (RES_W - 1));

	// configuration address map
	localparam cfg_addr_t CFG_ADDR_CHUNKS = 1'b0;
	localparam cfg_addr_t CFG_ADDR_SHIFT = 1'b1;

endpackage

//--- dpe_cfg_regs.sv
/*
 * configuration registers for the chunk count and the output shift,
 * with a one-cycle restart pulse following every write
 */
`timescale 1ns/10ps

module dpe_cfg_regs
	import dpe_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_cfg_wr,
	input  cfg_addr_t  i_cfg_addr,
	input  cfg_data_t  i_cfg_data,
	output chunk_cnt_t o_chunks,
	output shift_t     o_shift,
	output logic       o_restart
);

	// a zero in both registers means one chunk per vector and no scaling
	always_ff @(posedge clk) begin
		if (rst) begin
			o_chunks <= '0;
			o_shift <= '0;
			o_restart <= 1'b0;
		end else begin
			// the restart pulse lines up with the cycle the new value shows
			o_restart <= i_cfg_wr;
			if (i_cfg_wr) begin
				case (i_cfg_addr)
					CFG_ADDR_CHUNKS: begin
						// the stored value is the chunk count minus one
						o_chunks <= chunk_cnt_t'(i_cfg_data);
					end
					CFG_ADDR_SHIFT: begin
						// a 32-bit sum never needs more than the low five bits
						o_shift <= shift_t'(i_cfg_data);
					end
				endcase
			end
		end
	end

endmodule

//--- dpe_mult_stage.sv
/*
 * operand input registers and the per-lane signed multipliers
 * for one beat, valid delayed alongside the data
 */
`timescale 1ns/10ps

module dpe_mult_stage
	import dpe_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  i_valid,
	input  data_t i_dataa,
	input  data_t i_datab,
	output logic  o_valid,
	output prod_t o_prod [LANES]
);

	// registered signed lanes of both operands
	elem_t lane_a [LANES];
	elem_t lane_b [LANES];
	// one valid bit per register level of this stage
	logic [MULT_LAT-1:0] vld_pipe;

	// the lane registers and products carry no reset, only valid does
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES; i++) begin
			// unpack lane i from the flat operand bus
			lane_a[i] <= elem_t'(i_dataa[i*ELEM_W +: ELEM_W]);
			lane_b[i] <= elem_t'(i_datab[i*ELEM_W +: ELEM_W]);
			// both lanes are signed, so the product is a full signed 16-bit
			o_prod[i] <= prod_t'(lane_a[i]) * prod_t'(lane_b[i]);
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[MULT_LAT-2:0], i_valid};
		end
	end

	assign o_valid = vld_pipe[MULT_LAT-1];

endmodule

//--- dpe_adder_tree.sv
/*
 * registered binary adder tree reducing the lane products of one beat
 * to a single partial sum over four levels
 */
`timescale 1ns/10ps

module dpe_adder_tree
	import dpe_pkg::*;
(
	input  logic  clk,
	input  logic  rst,
	input  logic  i_valid,
	input  prod_t i_prod [LANES],
	output logic  o_valid,
	output sum_t  o_sum
);

	// products widened to the sum width before any addition
	sum_t ext [LANES];
	// intermediate levels, each half the size of the one before
	sum_t lvl1 [LANES/2];
	sum_t lvl2 [LANES/4];
	sum_t lvl3 [LANES/8];
	// valid travels one bit per adder level
	logic [TREE_STAGES-1:0] vld_pipe;

	// sign extension comes from the cast of a signed product
	always_comb begin
		for (int i = 0; i < LANES; i++) begin
			ext[i] = sum_t'(i_prod[i]);
		end
	end

	// neighbouring pairs are added at every level, 16 to 8 to 4 to 2 to 1
	always_ff @(posedge clk) begin
		for (int i = 0; i < LANES/2; i++) begin
			lvl1[i] <= ext[2*i] + ext[2*i+1];
		end
		for (int i = 0; i < LANES/4; i++) begin
			lvl2[i] <= lvl1[2*i] + lvl1[2*i+1];
		end
		for (int i = 0; i < LANES/8; i++) begin
			lvl3[i] <= lvl2[2*i] + lvl2[2*i+1];
		end
		o_sum <= lvl3[0] + lvl3[1];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe <= '0;
		end else begin
			vld_pipe <= {vld_pipe[TREE_STAGES-2:0], i_valid};
		end
	end

	// the last valid bit leaves together with the final sum
	assign o_valid = vld_pipe[TREE_STAGES-1];

endmodule

//--- dpe_accumulator.sv
/*
 * chunk counter and running sum of the partial sums of one vector,
 * followed by the arithmetic shift and the saturating output register
 */
`timescale 1ns/10ps

module dpe_accumulator
	import dpe_pkg::*;
(
	input  logic       clk,
	input  logic       rst,
	input  logic       i_valid,
	input  sum_t       i_sum,
	input  chunk_cnt_t i_chunks,
	input  shift_t     i_shift,
	input  logic       i_restart,
	output logic       o_valid,
	output res_t       o_result,
	output logic       o_sat
);

	chunk_cnt_t cnt;
	sum_t acc;
	// total of the last completed vector, held for the output stage
	sum_t total;
	sum_t shifted;
	// bit 0 marks a new total, bit 1 the saturated result
	logic [ACC_LAT-1:0] vld_pipe;

	// counting and summing, restart drops whatever was gathered so far
	always_ff @(posedge clk) begin
		if (rst || i_restart) begin
			cnt <= '0;
			acc <= '0;
			vld_pipe[0] <= 1'b0;
		end else begin
			vld_pipe[0] <= 1'b0;
			if (i_valid) begin
				if (cnt == i_chunks) begin
					// last chunk of the vector, hand the total over and start afresh
					total <= acc + i_sum;
					vld_pipe[0] <= 1'b1;
					cnt <= '0;
					acc <= '0;
				end else begin
					acc <= acc + i_sum;
					cnt <= cnt + 1'b1;
				end
			end
		end
	end

	// arithmetic shift keeps the sign of negative totals
	assign shifted = total >>> i_shift;

	always_ff @(posedge clk) begin
		if (shifted > RES_MAX) begin
			o_result <= res_t'(RES_MAX);
			o_sat <= 1'b1;
		end else if (shifted < RES_MIN) begin
			o_result <= res_t'(RES_MIN);
			o_sat <= 1'b1;
		end else begin
			o_result <= res_t'(shifted);
			o_sat <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			vld_pipe[ACC_LAT-1] <= 1'b0;
		end else begin
			vld_pipe[ACC_LAT-1] <= vld_pipe[ACC_LAT-2];
		end
	end

	assign o_valid = vld_pipe[ACC_LAT-1];

endmodule

//--- dpe_top.sv
/*
 * top level of the int8 dot product engine with the configuration
 * registers, multiply stage, adder tree and accumulator
 */
`timescale 1ns/10ps

module dpe_top
	import dpe_pkg::*;
(
	input  logic      clk,
	input  logic      rst,
	input  logic      i_valid,
	input  data_t     i_dataa,
	input  data_t     i_datab,
	input  logic      i_cfg_wr,
	input  cfg_addr_t i_cfg_addr,
	input  cfg_data_t i_cfg_data,
	output logic      o_valid,
	output res_t      o_result,
	output logic      o_sat
);

	chunk_cnt_t chunks;
	shift_t shift;
	logic restart;
	// products of one beat and their valid
	prod_t prod [LANES];
	logic prod_valid;
	// partial sum of one beat and its valid
	sum_t psum;
	logic psum_valid;

	dpe_cfg_regs i_cfg_regs (
		.clk        (clk),
		.rst        (rst),
		.i_cfg_wr   (i_cfg_wr),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_data (i_cfg_data),
		.o_chunks   (chunks),
		.o_shift    (shift),
		.o_restart  (restart)
	);

	dpe_mult_stage i_mult_stage (
		.clk     (clk),
		.rst     (rst),
		.i_valid (i_valid),
		.i_dataa (i_dataa),
		.i_datab (i_datab),
		.o_valid (prod_valid),
		.o_prod  (prod)
	);

	dpe_adder_tree i_adder_tree (
		.clk     (clk),
		.rst     (rst),
		.i_valid (prod_valid),
		.i_prod  (prod),
		.o_valid (psum_valid),
		.o_sum   (psum)
	);

	// results leave here with no back-pressure
	dpe_accumulator i_accumulator (
		.clk       (clk),
		.rst       (rst),
		.i_valid   (psum_valid),
		.i_sum     (psum),
		.i_chunks  (chunks),
		.i_shift   (shift),
		.i_restart (restart),
		.o_valid   (o_valid),
		.o_result  (o_result),
		.o_sat     (o_sat)
	);

endmodule

//--- tb_clock_gen.sv
/*
 * clock and reset source of the testbench, 4 ns period,
 * reset held over the first two rising edges
 */
`timescale 1ns/10ps

module tb_clock_gen (
	output logic clk,
	output logic rst
);

	localparam int HALF_NS = 2;

	initial begin
		clk = 1'b0;
		forever #HALF_NS clk = ~clk;
	end

	// reset lifts on a falling edge so the DUT sees it cleanly
	initial begin
		rst = 1'b1;
		repeat (2) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
	end

endmodule

//--- dpe_tb.sv
/*
 * testbench of the dot product engine with random beats from a fixed seed,
 * a reference model with an expected-result queue, compare tasks and a watchdog
 */
`timescale 1ns/10ps

module dpe_tb
	import dpe_pkg::*;
;

	localparam int CLK_NS = 4;
	localparam int T1_BEATS = 40;
	localparam int T2_VECS = 10;
	localparam int MAX_GAP = 3;
	localparam int T3_VECS = 30;
	localparam int T4_CHUNKS = 8;
	localparam int T4_VECS = 6;
	localparam int T5_BEATS = 2;
	localparam int T5_TAIL = 12;
	// output limits of the signed 16-bit result
	localparam longint RES_HI = (longint'(1) << (RES_W - 1)) - 1;
	localparam longint RES_LO = -(longint'(1) << (RES_W - 1));

	logic clk;
	logic rst;
	logic i_valid;
	data_t i_dataa;
	data_t i_datab;
	logic i_cfg_wr;
	cfg_addr_t i_cfg_addr;
	cfg_data_t i_cfg_data;
	logic o_valid;
	res_t o_result;
	logic o_sat;

	integer seed = 32'h633c_59e4;
	// count of rising edges since time zero that is stable on every falling edge
	int cyc = 0;
	// model state where the chunk count is the real number of beats per vector
	longint m_acc = 0;
	int m_cnt = 0;
	int m_chunks = 1;
	int m_shift = 0;
	// expected results in order along with the cycle their last beat was driven
	res_t exp_res[$];
	logic exp_sat[$];
	int exp_cyc[$];

	tb_clock_gen i_clock_gen (
		.clk (clk),
		.rst (rst)
	);

	dpe_top i_dut (
		.clk        (clk),
		.rst        (rst),
		.i_valid    (i_valid),
		.i_dataa    (i_dataa),
		.i_datab    (i_datab),
		.i_cfg_wr   (i_cfg_wr),
		.i_cfg_addr (i_cfg_addr),
		.i_cfg_data (i_cfg_data),
		.o_valid    (o_valid),
		.o_result   (o_result),
		.o_sat      (o_sat)
	);

	always @(posedge clk) begin
		cyc <= cyc + 1;
	end

	task automatic stop_on_error();
		$display("Result: FAILED");
		$fatal(1, "simulation stopped at the first error");
	endtask

	task automatic check_result(input res_t got, input res_t exp);
		if (got !== exp) begin
			$display("FAILED at %0t: o_result is %0d, expected %0d", $time, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_sat(input logic got, input logic exp);
		if (got !== exp) begin
			$display("FAILED at %0t: o_sat is %b, expected %b", $time, got, exp);
			stop_on_error();
		end
	endtask

	task automatic check_latency(input int got, input int exp);
		if (got != exp) begin
			$display("FAILED at %0t: result came %0d cycles after its last beat, expected %0d",
				$time, got, exp);
			stop_on_error();
		end
	endtask

	function automatic data_t rand_beat();
		return {$random(seed), $random(seed), $random(seed), $random(seed)};
	endfunction

	function automatic data_t fill_beat(input elem_t v);
		return {LANES{v}};
	endfunction

	// every lane picks one of the two int8 extremes on its own
	function automatic data_t extreme_beat();
		data_t b;
		integer r;
		for (int j = 0; j < LANES; j++) begin
			r = $random(seed);
			b[j*ELEM_W +: ELEM_W] = r[0] ? 8'h80 : 8'h7f;
		end
		return b;
	endfunction

	function automatic int rand_gap();
		return {$random(seed)} % (MAX_GAP + 1);
	endfunction

	// plain dot product of one beat computed lane by lane in signed arithmetic
	function automatic longint beat_dot(input data_t a, input data_t b);
		longint s;
		elem_t ea;
		elem_t eb;
		s = 0;
		for (int j = 0; j < LANES; j++) begin
			ea = elem_t'(a[j*ELEM_W +: ELEM_W]);
			eb = elem_t'(b[j*ELEM_W +: ELEM_W]);
			s += longint'(ea) * longint'(eb);
		end
		return s;
	endfunction

	// adds one beat to the model and queues the result once a vector completes
	task automatic model_beat(input data_t a, input data_t b);
		longint sh;
		m_acc += beat_dot(a, b);
		m_cnt++;
		if (m_cnt == m_chunks) begin
			sh = m_acc >>> m_shift;
			if (sh > RES_HI) begin
				exp_res.push_back(res_t'(RES_HI));
				exp_sat.push_back(1'b1);
			end else if (sh < RES_LO) begin
				exp_res.push_back(res_t'(RES_LO));
				exp_sat.push_back(1'b1);
			end else begin
				exp_res.push_back(res_t'(sh));
				exp_sat.push_back(1'b0);
			end
			exp_cyc.push_back(cyc);
			m_acc = 0;
			m_cnt = 0;
		end
	endtask

	task automatic idle(input int n);
		repeat (n) begin
			@(negedge clk);
			i_valid = 1'b0;
		end
	endtask

	task automatic send_beat(input data_t a, input data_t b);
		@(negedge clk);
		i_valid = 1'b1;
		i_dataa = a;
		i_datab = b;
		model_beat(a, b);
	endtask

	// any write restarts the vector, so the model drops its partial sum too
	task automatic write_cfg(input cfg_addr_t addr, input cfg_data_t data);
		@(negedge clk);
		i_valid = 1'b0;
		i_cfg_wr = 1'b1;
		i_cfg_addr = addr;
		i_cfg_data = data;
		if (addr == CFG_ADDR_CHUNKS) begin
			m_chunks = int'(data) + 1;
		end else begin
			m_shift = int'(data[4:0]);
		end
		m_acc = 0;
		m_cnt = 0;
		@(negedge clk);
		i_cfg_wr = 1'b0;
	endtask

	// groups of n beats with random idle gaps followed by a full drain
	task automatic run_groups(input int n, input int vecs);
		write_cfg(CFG_ADDR_CHUNKS, cfg_data_t'(n - 1));
		repeat (vecs) begin
			repeat (n) begin
				send_beat(rand_beat(), rand_beat());
				idle(rand_gap());
			end
		end
		idle(DPE_LAT);
	endtask

	// worst case cycle count of all tests with every write taken as two cycles
	function automatic int run_budget();
		int t;
		t = 20 + T1_BEATS * (2 + MAX_GAP) + DPE_LAT;
		t += 2 * (2 + T2_VECS * 7 * (1 + MAX_GAP) + DPE_LAT);
		t += 2 + T3_VECS * (2 + 2 * (1 + MAX_GAP) + DPE_LAT);
		t += 4 + T4_VECS * T4_CHUNKS + DPE_LAT;
		t += 6 + T5_BEATS + T5_TAIL + 2 * DPE_LAT + 4;
		return t + 50;
	endfunction

	// outputs only change on rising edges, so the falling edge sees them settled
	always @(negedge clk) begin
		if (!rst) begin
			if (o_valid !== 1'b0 && o_valid !== 1'b1) begin
				$display("o_valid is unknown at %0t after reset", $time);
				stop_on_error();
			end else if (o_valid === 1'b1) begin
				if (exp_res.size() == 0) begin
					$display("o_valid pulsed at %0t while no result was expected", $time);
					stop_on_error();
				end else begin
					check_latency(cyc - exp_cyc[0], DPE_LAT);
					check_result(o_result, exp_res[0]);
					check_sat(o_sat, exp_sat[0]);
					void'(exp_res.pop_front());
					void'(exp_sat.pop_front());
					void'(exp_cyc.pop_front());
				end
			end else if (exp_cyc.size() != 0 && cyc - exp_cyc[0] > DPE_LAT) begin
				$display("a result due at %0t never showed up on o_valid", $time);
				stop_on_error();
			end
		end
	end

	initial begin
		#(run_budget() * CLK_NS);
		$display("the watchdog ran out before the tests finished");
		stop_on_error();
	end

	initial begin
		i_valid = 1'b0;
		i_dataa = '0;
		i_datab = '0;
		i_cfg_wr = 1'b0;
		i_cfg_addr = '0;
		i_cfg_data = '0;
		wait (rst === 1'b1);
		wait (rst === 1'b0);
		// the default configuration gives one result per beat after a quiet stretch
		idle(10);
		repeat (T1_BEATS) send_beat(rand_beat(), rand_beat());
		repeat (T1_BEATS) begin
			send_beat(rand_beat(), rand_beat());
			idle(rand_gap());
		end
		idle(DPE_LAT);
		// groups of three and seven chunks
		run_groups(3, T2_VECS);
		run_groups(7, T2_VECS);
		// a fresh random shift for each two-beat vector
		write_cfg(CFG_ADDR_CHUNKS, 8'd1);
		repeat (T3_VECS) begin
			write_cfg(CFG_ADDR_SHIFT, cfg_data_t'({$random(seed)} % 32));
			repeat (2) begin
				send_beat(rand_beat(), rand_beat());
				idle(rand_gap());
			end
			idle(DPE_LAT);
		end
		// extreme operands over many chunks drive the output into both clamps
		write_cfg(CFG_ADDR_SHIFT, 8'd0);
		write_cfg(CFG_ADDR_CHUNKS, cfg_data_t'(T4_CHUNKS - 1));
		for (int v = 0; v < T4_VECS; v++) begin
			repeat (T4_CHUNKS) begin
				case (v % 3)
					0: send_beat(fill_beat(-8'sd128), fill_beat(-8'sd128));
					1: send_beat(fill_beat(-8'sd128), fill_beat(8'sd127));
					default: send_beat(extreme_beat(), extreme_beat());
				endcase
			end
		end
		idle(DPE_LAT);
		// a partial vector is drained and then thrown away by the next write
		write_cfg(CFG_ADDR_CHUNKS, 8'd3);
		repeat (T5_BEATS) send_beat(rand_beat(), rand_beat());
		idle(DPE_LAT);
		write_cfg(CFG_ADDR_CHUNKS, 8'd0);
		write_cfg(CFG_ADDR_SHIFT, 8'd2);
		repeat (T5_TAIL) send_beat(rand_beat(), rand_beat());
		idle(DPE_LAT + 4);
		if (exp_res.size() != 0) begin
			$display("%0d expected results were still waiting at the end", exp_res.size());
			$display("Result: FAILED");
			$fatal(1, "results left over");
		end else begin
			$display("Result: PASSED");
			$finish;
		end
	end

endmodule

//--- dpe_project.f
dpe_pkg.sv
dpe_cfg_regs.sv
dpe_mult_stage.sv
dpe_adder_tree.sv
dpe_accumulator.sv
dpe_top.sv
tb_clock_gen.sv
dpe_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the dot product engine testbench with Verilator, runs it,
# and decides pass or fail from the simulation log.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --top-module dpe_tb -f dpe_project.f -Mdir obj_dir -o dpe_sim
build_status=$?
if [ "$build_status" -ne 0 ]; then
	echo "Verilator build failed with status $build_status"
	exit 1
fi

./obj_dir/dpe_sim > "$LOG" 2>&1
run_status=$?
cat "$LOG"

if grep -q "Result: FAILED" "$LOG"; then
	echo "Simulation reported a failure, see $LOG"
	exit 1
fi

if [ "$run_status" -ne 0 ]; then
	echo "Simulation exited with status $run_status"
	exit 1
fi

if ! grep -q "Result: PASSED" "$LOG"; then
	echo "Simulation ended without a result line"
	exit 1
fi

echo "Simulation passed"
exit 0
